/* include/mem_attach_consts.svh */
`ifndef MEM_ATTACH_CONSTS_SVH
`define MEM_ATTACH_CONSTS_SVH

// opb address windows
`define MEM_BASE    32'h8000_0000
`define MEM_HIGH    32'h8FFF_FFFF
`define REG_BASE    32'hA000_0000
`define REG_HIGH    32'hA000_000F

// byte offsets inside the register window
`define REG_CTRL    32'h0
`define REG_RDCNT   32'h4
`define REG_WRCNT   32'h8
`define REG_ID      32'hC

`define ATTACH_ID   32'h4D0A_0100

// controller user interface widths
`define DRAM_DATA_W 288
`define DRAM_MASK_W 36
`define DRAM_ADDR_W 32

`endif

/* hdl/mem_attach_pkg.sv */
package mem_attach_pkg;

   typedef enum logic [2:0] {
      OPB_IDLE,
      OPB_DECODE,
      OPB_MEM_WAIT,
      OPB_REG_ACC,      // register access or disabled memory access
      OPB_DONE
   } opb_state_e;

   typedef enum logic [2:0] {
      DRAM_IDLE,
      DRAM_CMD_HOLD,
      DRAM_WR_BEAT0,
      DRAM_WR_BEAT1,
      DRAM_RD_WAIT,
      DRAM_RESP
   } dram_state_e;

   typedef enum logic [2:0] {
      CMD_WRITE = 3'b000,
      CMD_READ  = 3'b001
   } dram_cmd_e;

   typedef struct packed {
      logic        valid;
      logic        rnw;
      logic [29:0] addr;   // word address from MEM_BASE
      logic [31:0] data;
      logic [3:0]  be;     // bit 3 is the msb byte
   } mem_req_t;

   typedef struct packed {
      logic        done;
      logic        error;
      logic [31:0] data;
   } mem_rsp_t;

   typedef struct packed {
      logic        valid;
      logic        rnw;
      logic [1:0]  offset; // word index in the window
      logic [31:0] data;
   } reg_req_t;

endpackage

/* hdl/opb_slave_fsm.sv */
`include "mem_attach_consts.svh"

module opb_slave_fsm (
   input  logic                     OPB_Clk,
   input  logic                     dram_rst,
   input  logic [0:31]              OPB_ABus,
   input  logic [0:3]               OPB_BE,
   input  logic [0:31]              OPB_DBus,
   input  logic                     OPB_RNW,
   input  logic                     OPB_select,
   input  mem_attach_pkg::mem_rsp_t mem_rsp,
   input  logic [31:0]              reg_rdata,
   input  logic                     mem_enable,
   output logic [0:31]              Sl_DBus,
   output logic                     Sl_xferAck,
   output logic                     Sl_errAck,
   output logic                     Sl_toutSup,
   output logic                     Sl_retry,
   output mem_attach_pkg::mem_req_t mem_req,
   output mem_attach_pkg::reg_req_t reg_req
);
   import mem_attach_pkg::*;

   opb_state_e  state;
   logic [31:0] mem_off;
   logic [31:0] reg_off;
   logic        mem_hit;
   logic        reg_hit;

   always_comb begin
      mem_off = OPB_ABus - `MEM_BASE;
      reg_off = OPB_ABus - `REG_BASE;
      mem_hit = (OPB_ABus >= `MEM_BASE) && (OPB_ABus <= `MEM_HIGH);
      reg_hit = (OPB_ABus >= `REG_BASE) && (OPB_ABus <= `REG_HIGH);
   end

   assign Sl_retry = 1'b0; // no retry support

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state         <= OPB_IDLE;
         Sl_xferAck    <= 1'b0;
         Sl_errAck     <= 1'b0;
         Sl_toutSup    <= 1'b0;
         Sl_DBus       <= '0;
         mem_req.valid <= 1'b0;
         reg_req.valid <= 1'b0;
      end else begin
         Sl_xferAck    <= 1'b0;
         Sl_errAck     <= 1'b0;
         Sl_DBus       <= '0;
         reg_req.valid <= 1'b0; // one cycle pulse
         case (state)
            OPB_IDLE: begin
               if (OPB_select) begin
                  state      <= OPB_DECODE;
                  Sl_toutSup <= mem_hit && mem_enable; // dram latency unknown
               end
            end
            OPB_DECODE: begin
               if (!OPB_select) begin
                  state      <= OPB_IDLE;
                  Sl_toutSup <= 1'b0;
               end else if (reg_hit) begin
                  reg_req <= '{valid: 1'b1, rnw: OPB_RNW, offset: reg_off[3:2],
                               data: OPB_DBus};
                  state   <= OPB_REG_ACC;
               end else if (mem_hit && !mem_enable) begin
                  state <= OPB_REG_ACC; // no reg pulse, ends in errAck
               end else if (mem_hit) begin
                  mem_req <= '{valid: 1'b1, rnw: OPB_RNW, addr: mem_off[31:2],
                               data: OPB_DBus, be: OPB_BE};
                  state   <= OPB_MEM_WAIT;
               end
               // unmapped address waits here for select to drop
            end
            OPB_MEM_WAIT: begin
               if (!OPB_select) begin
                  state         <= OPB_IDLE; // master gave up
                  mem_req.valid <= 1'b0;
                  Sl_toutSup    <= 1'b0;
               end else if (mem_rsp.done) begin
                  mem_req.valid <= 1'b0;
                  Sl_toutSup    <= 1'b0;
                  Sl_xferAck    <= !mem_rsp.error;
                  Sl_errAck     <= mem_rsp.error;
                  if (mem_req.rnw && !mem_rsp.error) begin
                     Sl_DBus <= mem_rsp.data;
                  end
                  state <= OPB_DONE;
               end
            end
            OPB_REG_ACC: begin
               Sl_xferAck <= reg_req.valid;
               Sl_errAck  <= !reg_req.valid;
               if (reg_req.valid && reg_req.rnw) begin
                  Sl_DBus <= reg_rdata;
               end
               state <= OPB_DONE;
            end
            OPB_DONE: begin
               state <= OPB_IDLE; // ack cycle
            end
            default: begin
               state <= OPB_IDLE;
            end
         endcase
      end
   end

   ack_exclusive: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      !(Sl_xferAck && Sl_errAck))
      else $error("xferAck and errAck asserted together");

endmodule

/* hdl/dram_cmd_seq.sv */
`include "mem_attach_consts.svh"

module dram_cmd_seq (
   input  logic                     OPB_Clk,
   input  logic                     dram_rst,
   input  mem_attach_pkg::mem_req_t mem_req,
   input  logic [`DRAM_DATA_W-1:0]  dram_rd_data,
   input  logic                     dram_rd_data_end,
   input  logic                     dram_rd_data_valid,
   input  logic                     dram_rdy,
   input  logic                     dram_wdf_rdy,
   output mem_attach_pkg::mem_rsp_t mem_rsp,
   output logic                     rd_done,
   output logic                     wr_done,
   output logic [`DRAM_ADDR_W-1:0]  dram_addr,
   output logic [2:0]               dram_cmd,
   output logic                     dram_en,
   output logic [`DRAM_DATA_W-1:0]  dram_wdf_data,
   output logic                     dram_wdf_end,
   output logic [`DRAM_MASK_W-1:0]  dram_wdf_mask,
   output logic                     dram_wdf_wren
);
   import mem_attach_pkg::*;

   dram_state_e state;
   dram_cmd_e   cmd_q;
   logic        taken;   // current request already started
   logic        rd_got;  // first read beat captured
   logic        rd_bad;

   assign dram_cmd = cmd_q;

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         state         <= DRAM_IDLE;
         taken         <= 1'b0;
         dram_en       <= 1'b0;
         dram_wdf_wren <= 1'b0;
         dram_wdf_end  <= 1'b0;
         mem_rsp.done  <= 1'b0;
         rd_done       <= 1'b0;
         wr_done       <= 1'b0;
      end else begin
         mem_rsp.done <= 1'b0;
         rd_done      <= 1'b0;
         wr_done      <= 1'b0;
         if (!mem_req.valid) begin
            taken <= 1'b0; // rearm for the next rising edge of valid
         end
         case (state)
            DRAM_IDLE: begin
               if (mem_req.valid && !taken) begin
                  taken         <= 1'b1;
                  cmd_q         <= mem_req.rnw ? CMD_READ : CMD_WRITE;
                  dram_addr     <= `DRAM_ADDR_W'(mem_req.addr);
                  dram_en       <= 1'b1;
                  dram_wdf_data <= `DRAM_DATA_W'(mem_req.data); // word in low lane
                  dram_wdf_mask <= {{(`DRAM_MASK_W-4){1'b1}}, ~mem_req.be};
                  rd_got        <= 1'b0;
                  rd_bad        <= 1'b0;
                  state         <= DRAM_CMD_HOLD;
               end
            end
            DRAM_CMD_HOLD: begin
               if (dram_rdy) begin
                  dram_en <= 1'b0; // command accepted
                  if (cmd_q == CMD_WRITE) begin
                     dram_wdf_wren <= 1'b1;
                     dram_wdf_end  <= 1'b0;
                     state         <= DRAM_WR_BEAT0;
                  end else begin
                     state <= DRAM_RD_WAIT;
                  end
               end
            end
            DRAM_WR_BEAT0: begin
               if (dram_wdf_rdy) begin
                  dram_wdf_end  <= 1'b1;
                  dram_wdf_mask <= '1; // second beat writes nothing
                  state         <= DRAM_WR_BEAT1;
               end
            end
            DRAM_WR_BEAT1: begin
               if (dram_wdf_rdy) begin
                  dram_wdf_wren <= 1'b0;
                  dram_wdf_end  <= 1'b0;
                  state         <= DRAM_RESP;
               end
            end
            DRAM_RD_WAIT: begin
               if (dram_rd_data_valid && !rd_got) begin
                  mem_rsp.data <= dram_rd_data[31:0];
                  rd_got       <= 1'b1;
               end
               if (dram_rd_data_end) begin
                  rd_bad <= !(rd_got || dram_rd_data_valid); // burst without data
                  state  <= DRAM_RESP;
               end
            end
            DRAM_RESP: begin
               mem_rsp.done  <= taken; // dropped if opb side abandoned
               mem_rsp.error <= rd_bad;
               rd_done       <= (cmd_q == CMD_READ);
               wr_done       <= (cmd_q == CMD_WRITE);
               state         <= DRAM_IDLE;
            end
            default: begin
               state <= DRAM_IDLE;
            end
         endcase
      end
   end

   cmd_stable: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      dram_en && !dram_rdy |=> dram_en && $stable(dram_cmd) && $stable(dram_addr))
      else $error("dram command changed before dram_rdy");

   beat_order: assert property (@(posedge OPB_Clk) disable iff (dram_rst)
      dram_wdf_wren && dram_wdf_end |->
         $past(dram_wdf_wren && (dram_wdf_end || dram_wdf_rdy)))
      else $error("write beat two without accepted beat one");

endmodule

/* hdl/attach_ctrl_regs.sv */
`include "mem_attach_consts.svh"

module attach_ctrl_regs (
   input  logic                     OPB_Clk,
   input  logic                     dram_rst,
   input  mem_attach_pkg::reg_req_t reg_req,
   input  logic                     rd_done,
   input  logic                     wr_done,
   output logic [31:0]              reg_rdata,
   output logic                     mem_enable
);
   localparam logic [1:0] ctrl_idx  = 2'(`REG_CTRL >> 2);
   localparam logic [1:0] rdcnt_idx = 2'(`REG_RDCNT >> 2);
   localparam logic [1:0] wrcnt_idx = 2'(`REG_WRCNT >> 2);
   localparam logic [1:0] id_idx    = 2'(`REG_ID >> 2);

   logic [31:0] rd_cnt;
   logic [31:0] wr_cnt;
   logic        reg_wr;

   assign reg_wr = reg_req.valid && !reg_req.rnw;

   always_ff @(posedge OPB_Clk) begin
      if (dram_rst) begin
         mem_enable <= 1'b1;
         rd_cnt     <= '0;
         wr_cnt     <= '0;
      end else begin
         if (reg_wr && reg_req.offset == ctrl_idx) begin
            mem_enable <= reg_req.data[0];
         end
         if (reg_wr && reg_req.offset == rdcnt_idx) begin
            rd_cnt <= '0; // any write clears
         end else if (rd_done) begin
            rd_cnt <= rd_cnt + 32'd1;
         end
         if (reg_wr && reg_req.offset == wrcnt_idx) begin
            wr_cnt <= '0;
         end else if (wr_done) begin
            wr_cnt <= wr_cnt + 32'd1;
         end
      end
   end

   always_comb begin
      reg_rdata = '0;
      case (reg_req.offset)
         ctrl_idx:  reg_rdata = {31'b0, mem_enable};
         rdcnt_idx: reg_rdata = rd_cnt;
         wrcnt_idx: reg_rdata = wr_cnt;
         id_idx:    reg_rdata = `ATTACH_ID;
      endcase
   end

endmodule

/* hdl/mem_opb_attach.sv */
`include "mem_attach_consts.svh"

module mem_opb_attach (
   input  logic                    OPB_Clk,
   input  logic                    dram_rst,
   input  logic [0:31]             OPB_ABus,
   input  logic [0:3]              OPB_BE,
   input  logic [0:31]             OPB_DBus,
   input  logic                    OPB_RNW,
   input  logic                    OPB_select,
   output logic [0:31]             Sl_DBus,
   output logic                    Sl_xferAck,
   output logic                    Sl_errAck,
   output logic                    Sl_toutSup,
   output logic                    Sl_retry,
   input  logic [`DRAM_DATA_W-1:0] dram_rd_data,
   input  logic                    dram_rd_data_end,
   input  logic                    dram_rd_data_valid,
   input  logic                    dram_rdy,
   input  logic                    dram_wdf_rdy,
   output logic [`DRAM_ADDR_W-1:0] dram_addr,
   output logic [2:0]              dram_cmd,
   output logic                    dram_en,
   output logic [`DRAM_DATA_W-1:0] dram_wdf_data,
   output logic                    dram_wdf_end,
   output logic [`DRAM_MASK_W-1:0] dram_wdf_mask,
   output logic                    dram_wdf_wren
);
   import mem_attach_pkg::*;

   mem_req_t    mem_req;
   mem_rsp_t    mem_rsp;
   reg_req_t    reg_req;
   logic [31:0] reg_rdata;
   logic        mem_enable;
   logic        rd_done;
   logic        wr_done;

   opb_slave_fsm i_opb_fsm (
      .OPB_Clk(OPB_Clk), .dram_rst(dram_rst),
      .OPB_ABus(OPB_ABus), .OPB_BE(OPB_BE), .OPB_DBus(OPB_DBus),
      .OPB_RNW(OPB_RNW), .OPB_select(OPB_select),
      .mem_rsp(mem_rsp), .reg_rdata(reg_rdata), .mem_enable(mem_enable),
      .Sl_DBus(Sl_DBus), .Sl_xferAck(Sl_xferAck), .Sl_errAck(Sl_errAck),
      .Sl_toutSup(Sl_toutSup), .Sl_retry(Sl_retry),
      .mem_req(mem_req), .reg_req(reg_req)
   );

   dram_cmd_seq i_dram_seq (
      .OPB_Clk(OPB_Clk), .dram_rst(dram_rst), .mem_req(mem_req),
      .dram_rd_data(dram_rd_data), .dram_rd_data_end(dram_rd_data_end),
      .dram_rd_data_valid(dram_rd_data_valid), .dram_rdy(dram_rdy),
      .dram_wdf_rdy(dram_wdf_rdy), .mem_rsp(mem_rsp),
      .rd_done(rd_done), .wr_done(wr_done),
      .dram_addr(dram_addr), .dram_cmd(dram_cmd), .dram_en(dram_en),
      .dram_wdf_data(dram_wdf_data), .dram_wdf_end(dram_wdf_end),
      .dram_wdf_mask(dram_wdf_mask), .dram_wdf_wren(dram_wdf_wren)
   );

   attach_ctrl_regs i_ctrl_regs (
      .OPB_Clk(OPB_Clk), .dram_rst(dram_rst), .reg_req(reg_req),
      .rd_done(rd_done), .wr_done(wr_done),
      .reg_rdata(reg_rdata), .mem_enable(mem_enable)
   );

endmodule

/* verification/tb_dram_model.sv */
`include "mem_attach_consts.svh"

module tb_dram_model #(
   parameter logic [31:0] seed_init = 32'h1
) (
   input  logic                    OPB_Clk,
   input  logic                    dram_rst,
   input  logic [`DRAM_ADDR_W-1:0] dram_addr,
   input  logic [2:0]              dram_cmd,
   input  logic                    dram_en,
   input  logic [`DRAM_DATA_W-1:0] dram_wdf_data,
   input  logic                    dram_wdf_end,
   input  logic [`DRAM_MASK_W-1:0] dram_wdf_mask,
   input  logic                    dram_wdf_wren,
   output logic [`DRAM_DATA_W-1:0] dram_rd_data,
   output logic                    dram_rd_data_end,
   output logic                    dram_rd_data_valid,
   output logic                    dram_rdy,
   output logic                    dram_wdf_rdy
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] mem [0:63];
   logic [5:0]  wr_addr;
   logic [5:0]  rd_q [$];   // accepted read commands
   logic [31:0] rd_word;
   logic        beat_two;
   integer      seed = seed_init;
   int          delay;

   initial begin
      dram_rd_data       = '0;
      dram_rd_data_end   = 1'b0;
      dram_rd_data_valid = 1'b0;
      dram_rdy           = 1'b0;
      dram_wdf_rdy       = 1'b0;
      beat_two           = 1'b0;
      delay              = 0;
   end

   // commands and write beats are taken at the rising edge
   always @(posedge OPB_Clk) begin
      if (dram_rst) begin
         rd_q.delete();
      end else begin
         if (dram_en && dram_rdy) begin
            if (dram_cmd == 3'b001) begin
               rd_q.push_back(dram_addr[5:0]);
            end else begin
               wr_addr = dram_addr[5:0];
            end
         end
         if (dram_wdf_wren && dram_wdf_rdy && !dram_wdf_end) begin
            for (int i = 0; i < 4; i++) begin
               if (!dram_wdf_mask[i]) begin
                  mem[wr_addr][8*i +: 8] = dram_wdf_data[8*i +: 8]; // low lane only
               end
            end
         end
      end
   end

   always @(negedge OPB_Clk) begin
      dram_rdy           = ($unsigned($random(seed)) % 4) != 0; // stall about 1 in 4
      dram_wdf_rdy       = ($unsigned($random(seed)) % 4) != 0;
      dram_rd_data_valid = 1'b0;
      dram_rd_data_end   = 1'b0;
      if (dram_rst) begin
         delay    = 0;
         beat_two = 1'b0;
      end else if (beat_two) begin
         dram_rd_data_valid = 1'b1;
         dram_rd_data_end   = 1'b1;
         dram_rd_data       = {9{~rd_word}}; // must not be captured
         beat_two           = 1'b0;
      end else if (delay > 0) begin
         delay = delay - 1;
         if (delay == 0) begin
            dram_rd_data_valid = 1'b1;
            dram_rd_data       = {{8{$random(seed)}}, rd_word}; // noise above the word
            beat_two           = 1'b1;
         end
      end else if (rd_q.size() > 0) begin
         rd_word = mem[rd_q.pop_front()];
         delay   = 2 + $unsigned($random(seed)) % 5;
      end
   end

endmodule

/* verification/tb_mem_opb_attach.sv */
`include "mem_attach_consts.svh"

module tb_mem_opb_attach;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_words       = 64;
   localparam int n_init        = 4;           // register reads after reset
   localparam int n_rand        = 150;
   localparam int n_off         = 12;          // memory accesses while disabled
   localparam int n_tail        = 2 * n_off + 8;
   localparam int n_acc         = n_init + n_words + n_rand + n_tail;
   localparam int timeout_limit = n_acc * 20 + 100;

   logic                    OPB_Clk;
   logic                    dram_rst;
   logic [0:31]             OPB_ABus;
   logic [0:3]              OPB_BE;
   logic [0:31]             OPB_DBus;
   logic                    OPB_RNW;
   logic                    OPB_select;
   logic [0:31]             Sl_DBus;
   logic                    Sl_xferAck;
   logic                    Sl_errAck;
   logic                    Sl_toutSup;
   logic                    Sl_retry;
   logic [`DRAM_DATA_W-1:0] dram_rd_data;
   logic                    dram_rd_data_end;
   logic                    dram_rd_data_valid;
   logic                    dram_rdy;
   logic                    dram_wdf_rdy;
   logic [`DRAM_ADDR_W-1:0] dram_addr;
   logic [2:0]              dram_cmd;
   logic                    dram_en;
   logic [`DRAM_DATA_W-1:0] dram_wdf_data;
   logic                    dram_wdf_end;
   logic [`DRAM_MASK_W-1:0] dram_wdf_mask;
   logic                    dram_wdf_wren;

   logic [31:0] ref_mem [0:n_words-1]; // reference memory image
   logic        ref_en;
   logic [31:0] ref_rd;
   logic [31:0] ref_wr;
   integer      seed = 32'h9609_1d91;
   int          cycle_cnt;

   mem_opb_attach i_dut (.*);

   tb_dram_model #(.seed_init(32'h9609_1d91)) i_dram_model (.*);

   initial begin
      OPB_Clk = 1'b0;
      forever #10 OPB_Clk = ~OPB_Clk;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < timeout_limit) begin
         @(posedge OPB_Clk);
         cycle_cnt++;
      end
      $display("Timeout: no result after %0d clock cycles", timeout_limit);
      $display("Test failed");
      $fatal(1, "simulation timeout");
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // write mask outside the word lane, and all of beat two
   always @(posedge OPB_Clk) begin
      if (!dram_rst && dram_wdf_wren && dram_wdf_rdy) begin
         check_value("dram_wdf_mask", dram_wdf_mask[`DRAM_MASK_W-1:4], 32'hFFFF_FFFF);
         if (dram_wdf_end) begin
            check_value("dram_wdf_mask", dram_wdf_mask[3:0], 32'hF);
         end
      end
   end

   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] wdata,
                                               input logic [3:0] be);
      logic [31:0] res;
      res = old;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) begin
            res[8*i +: 8] = wdata[8*i +: 8];
         end
      end
      return res;
   endfunction

   // one OPB transfer, select held until an ack, then one idle cycle
   task automatic opb_access(input logic rnw, input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata, input logic exp_err,
                             input logic mem_path, output logic [31:0] rdata);
      int   cycles;
      logic acked;
      OPB_ABus   = addr;
      OPB_BE     = be;
      OPB_DBus   = rnw ? 32'h0 : wdata;
      OPB_RNW    = rnw;
      OPB_select = 1'b1;
      cycles     = 0;
      acked      = 1'b0;
      while (!acked) begin
         @(negedge OPB_Clk);
         cycles++;
         acked = Sl_xferAck || Sl_errAck;
         if (!acked) begin
            check_value("Sl_toutSup", Sl_toutSup, mem_path); // dram path only
            check_value("Sl_DBus", Sl_DBus, 32'h0);
         end
      end
      check_value("Sl_errAck", Sl_errAck, exp_err);
      check_value("Sl_xferAck", Sl_xferAck, !exp_err);
      check_value("Sl_toutSup", Sl_toutSup, 1'b0);
      check_value("Sl_retry", Sl_retry, 1'b0);
      if (!mem_path) begin
         check_value("ack latency", cycles, 3);
      end
      if (!rnw || exp_err) begin
         check_value("Sl_DBus", Sl_DBus, 32'h0);
      end
      rdata      = Sl_DBus;
      OPB_select = 1'b0;
      OPB_ABus   = '0;
      OPB_BE     = '0;
      OPB_DBus   = '0;
      OPB_RNW    = 1'b0;
      @(negedge OPB_Clk);
      check_value("Sl_xferAck", Sl_xferAck, 1'b0); // exactly one ack
      check_value("Sl_errAck", Sl_errAck, 1'b0);
      check_value("Sl_DBus", Sl_DBus, 32'h0);
   endtask

   task automatic mem_write(input int idx, input logic [3:0] be, input logic [31:0] data);
      logic [31:0] rdata;
      opb_access(1'b0, `MEM_BASE + 4 * idx, be, data, !ref_en, ref_en, rdata);
      if (ref_en) begin
         ref_mem[idx] = merge_bytes(ref_mem[idx], data, be);
         ref_wr++;
      end
   endtask

   task automatic mem_read(input int idx);
      logic [31:0] rdata;
      opb_access(1'b1, `MEM_BASE + 4 * idx, 4'hF, 32'h0, !ref_en, ref_en, rdata);
      if (ref_en) begin
         check_value("Sl_DBus", rdata, ref_mem[idx]);
         ref_rd++;
      end
   endtask

   task automatic reg_write(input logic [31:0] off, input logic [31:0] data);
      logic [31:0] rdata;
      opb_access(1'b0, `REG_BASE + off, 4'hF, data, 1'b0, 1'b0, rdata);
      case (off)
         `REG_CTRL:  ref_en = data[0];
         `REG_RDCNT: ref_rd = '0;
         `REG_WRCNT: ref_wr = '0;
         default:    ;
      endcase
   endtask

   task automatic reg_check(input logic [31:0] off);
      logic [31:0] rdata;
      logic [31:0] exp;
      case (off)
         `REG_CTRL:  exp = {31'b0, ref_en};
         `REG_RDCNT: exp = ref_rd;
         `REG_WRCNT: exp = ref_wr;
         default:    exp = `ATTACH_ID;
      endcase
      opb_access(1'b1, `REG_BASE + off, 4'hF, 32'h0, 1'b0, 1'b0, rdata);
      check_value("Sl_DBus", rdata, exp);
   endtask

   initial begin
      int          op;
      int          idx;
      int          off_idx [n_off];
      logic [3:0]  be;
      logic [31:0] data;
      dram_rst   = 1'b1;
      OPB_ABus   = '0;
      OPB_BE     = '0;
      OPB_DBus   = '0;
      OPB_RNW    = 1'b0;
      OPB_select = 1'b0;
      ref_en     = 1'b1;
      ref_rd     = '0;
      ref_wr     = '0;
      repeat (5) @(negedge OPB_Clk);
      check_value("Sl_xferAck", Sl_xferAck, 1'b0);
      check_value("Sl_errAck", Sl_errAck, 1'b0);
      check_value("Sl_toutSup", Sl_toutSup, 1'b0);
      check_value("dram_en", dram_en, 1'b0);
      check_value("dram_wdf_wren", dram_wdf_wren, 1'b0);
      dram_rst = 1'b0;
      @(negedge OPB_Clk);
      reg_check(`REG_ID);
      reg_check(`REG_CTRL);
      reg_check(`REG_RDCNT);
      reg_check(`REG_WRCNT);
      for (int i = 0; i < n_words; i++) begin
         mem_write(i, 4'hF, $random(seed)); // every word gets a full value first
      end
      for (int i = 0; i < n_rand; i++) begin
         op   = $unsigned($random(seed)) % 16;
         idx  = $unsigned($random(seed)) % n_words;
         data = $random(seed);
         be   = 4'($random(seed));
         if (op < 2) begin
            mem_write(idx, 4'hF, data);
         end else if (op < 6) begin
            mem_write(idx, be, data); // partial lanes
         end else if (op < 12) begin
            mem_read(idx);
         end else if (op == 12) begin
            reg_check(`REG_RDCNT);
         end else if (op == 13) begin
            reg_check(`REG_WRCNT);
         end else if (op == 14) begin
            reg_write(`REG_RDCNT, data);
         end else begin
            reg_write(`REG_WRCNT, data);
         end
      end
      reg_write(`REG_CTRL, 32'h0);
      reg_check(`REG_CTRL);
      for (int i = 0; i < n_off; i++) begin
         idx        = $unsigned($random(seed)) % n_words;
         data       = $random(seed);
         off_idx[i] = idx;
         if (data[0]) begin
            mem_write(idx, 4'hF, ~ref_mem[idx]); // would flip every bit
         end else begin
            mem_read(idx);
         end
      end
      reg_check(`REG_RDCNT);
      reg_check(`REG_WRCNT);
      reg_check(`REG_ID);
      reg_write(`REG_CTRL, 32'h1);
      for (int i = 0; i < n_off; i++) begin
         mem_read(off_idx[i]); // image untouched while off
      end
      reg_check(`REG_RDCNT);
      reg_check(`REG_WRCNT);
      $display("Test passed");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+include
hdl/mem_attach_pkg.sv
hdl/opb_slave_fsm.sv
hdl/dram_cmd_seq.sv
hdl/attach_ctrl_regs.sv
hdl/mem_opb_attach.sv
verification/tb_dram_model.sv
verification/tb_mem_opb_attach.sv
